//--- rtl/pe_array_consts.svh
`ifndef PE_ARRAY_CONSTS_SVH
`define PE_ARRAY_CONSTS_SVH

// ==============================
// array geometry
// ==============================

`define PE_ARRAY_DIM 8      // rows == columns

// ==============================
// data path
// ==============================

`define PE_DATA_W 16        // weight, map and result width

`endif

//--- rtl/pe_data_pkg.sv
package pe_data_pkg;

`include "pe_array_consts.svh"

    // ==============================
    // data-path words
    // ==============================

    // one unsigned operand or accumulator
    typedef logic [`PE_DATA_W-1:0] pe_word_t;

    // one word per column (weights) or per row (maps)
    typedef logic [`PE_ARRAY_DIM-1:0][`PE_DATA_W-1:0] pe_word_vec_t;

    // all accumulators, row-major, element r*DIM+c
    typedef logic [`PE_ARRAY_DIM*`PE_ARRAY_DIM-1:0][`PE_DATA_W-1:0] pe_result_vec_t;

endpackage

//--- rtl/pe_ctrl_pkg.sv
package pe_ctrl_pkg;

`include "pe_array_consts.svh"

    // ==============================
    // clear skew
    // ==============================

    // bit k is the clear strobe delayed by k+1 cycles
    typedef logic [`PE_ARRAY_DIM-1:0] clear_taps_t;

endpackage

//--- rtl/pe.sv
`timescale 1ns/1ps

module pe
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_clear,
    input  pe_data_pkg::pe_word_t i_weight,
    input  pe_data_pkg::pe_word_t i_map,
    output pe_data_pkg::pe_word_t o_weight,
    output pe_data_pkg::pe_word_t o_map,
    output pe_data_pkg::pe_word_t o_result
);

    import pe_data_pkg::*;

    pe_word_t weight_q;     // to the PE below
    pe_word_t map_q;        // to the PE on the right
    pe_word_t acc_q;
    pe_word_t product;

    // low half of the product, unsigned
    assign product = i_weight * i_map;

    // operand forwarding, one hop per cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            weight_q <= '0;
            map_q    <= '0;
        end
        else
        begin
            weight_q <= i_weight;
            map_q    <= i_map;
        end
    end

    // load on clear, otherwise accumulate with wrap
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            acc_q <= '0;
        end
        else if (i_clear)
        begin
            acc_q <= product;
        end
        else
        begin
            acc_q <= acc_q + product;
        end
    end

    assign o_weight = weight_q;
    assign o_map    = map_q;
    assign o_result = acc_q;

    // an X on the clear tap would poison the accumulator for good
    clear_known_a: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(i_clear));

endmodule

//--- rtl/clear_skew.sv
`timescale 1ns/1ps

module clear_skew
#(
    parameter int N_STAGES = $bits(pe_ctrl_pkg::clear_taps_t)
)
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_clear,
    output pe_ctrl_pkg::clear_taps_t o_clear_taps
);

    import pe_ctrl_pkg::*;

    logic [N_STAGES-1:0] stage_q;

    // chain depth has to fill the tap word exactly
    if (N_STAGES != $bits(clear_taps_t))
    begin : g_bad_depth
        $error("clear_skew: N_STAGES does not match the tap width");
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stage_q <= '0;
        end
        else
        begin
            stage_q[0] <= i_clear;
            for (int k = 1; k < N_STAGES; k++)
            begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    assign o_clear_taps = stage_q;  // every stage is a tap

    // tap k trails the input strobe by k+1 cycles
    for (genvar k = 0; k < N_STAGES; k++)
    begin : g_tap_chk
        tap_delay_a: assert property (@(posedge clk) disable iff (!rst_n)
            $past(rst_n, k+1) |-> o_clear_taps[k] == $past(i_clear, k+1));
    end

endmodule

//--- rtl/pe_grid.sv
`timescale 1ns/1ps

`include "pe_array_consts.svh"

module pe_grid
#(
    parameter int DIM = `PE_ARRAY_DIM
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  pe_data_pkg::pe_word_vec_t   i_weight,
    input  pe_data_pkg::pe_word_vec_t   i_map,
    input  pe_ctrl_pkg::clear_taps_t    i_clear_taps,
    output pe_data_pkg::pe_result_vec_t o_result
);

    import pe_data_pkg::*;

    // ==============================
    // meshes
    // ==============================

    pe_word_t w_fwd [DIM][DIM];     // weight leaving PE(r,c) downwards
    pe_word_t m_fwd [DIM][DIM];     // map leaving PE(r,c) to the right
    pe_word_t acc   [DIM][DIM];

    // grid size must agree with the port types
    if ($bits(pe_word_vec_t) != DIM * $bits(pe_word_t))
    begin : g_bad_dim
        $error("pe_grid: DIM does not match the port word vectors");
    end

    // ==============================
    // PE placement
    // ==============================

    for (genvar r = 0; r < DIM; r++)
    begin : g_row
        for (genvar c = 0; c < DIM; c++)
        begin : g_col
            // diagonal skew of the clear
            localparam int TAP = (r < c) ? r : c;

            pe_word_t w_in;
            pe_word_t m_in;

            // top row is fed from the ports
            if (r == 0)
            begin : g_w_port
                assign w_in = i_weight[c];
            end
            else
            begin : g_w_mesh
                assign w_in = w_fwd[r-1][c];
            end

            // left column is fed from the ports
            if (c == 0)
            begin : g_m_port
                assign m_in = i_map[r];
            end
            else
            begin : g_m_mesh
                assign m_in = m_fwd[r][c-1];
            end

            pe pe_i
            (
                .clk      (clk),
                .rst_n    (rst_n),
                .i_clear  (i_clear_taps[TAP]),
                .i_weight (w_in),
                .i_map    (m_in),
                .o_weight (w_fwd[r][c]),
                .o_map    (m_fwd[r][c]),
                .o_result (acc[r][c])
            );
        end
    end

    // ==============================
    // result packing
    // ==============================

    // row-major, r*DIM+c
    always_comb
    begin
        for (int r = 0; r < DIM; r++)
        begin
            for (int c = 0; c < DIM; c++)
            begin
                o_result[r*DIM + c] = acc[r][c];
            end
        end
    end

endmodule

//--- rtl/pe_array.sv
`timescale 1ns/1ps

module pe_array
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  pe_data_pkg::pe_word_vec_t   i_weight,   // word c enters column c
    input  pe_data_pkg::pe_word_vec_t   i_map,      // word r enters row r
    input  logic                        i_clear,
    output pe_data_pkg::pe_result_vec_t o_result
);

    import pe_ctrl_pkg::*;

    // ==============================
    // clear skew
    // ==============================

    clear_taps_t clear_taps;    // tap k = clear delayed k+1 cycles

    clear_skew clear_skew_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_clear      (i_clear),
        .o_clear_taps (clear_taps)
    );

    // ==============================
    // PE grid
    // ==============================

    // weights go down, maps go right, results straight out
    pe_grid pe_grid_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_weight     (i_weight),
        .i_map        (i_map),
        .i_clear_taps (clear_taps),
        .o_result     (o_result)
    );

endmodule

//--- bench/pe_array_vectors.svh
`ifndef PE_ARRAY_VECTORS_SVH
`define PE_ARRAY_VECTORS_SVH

// ==============================
// stimulus table
// ==============================

localparam int NUM_VECTORS = 7;

string        vec_name   [NUM_VECTORS];
pe_word_vec_t vec_weight [NUM_VECTORS];     // word c enters column c
pe_word_vec_t vec_map    [NUM_VECTORS];     // word r enters row r
int           vec_hold   [NUM_VECTORS];     // edges with clear high, at least 20
int           vec_acc    [NUM_VECTORS];     // K, edges after clear falls
bit           vec_random [NUM_VECTORS];     // operands drawn at apply time

// operands follow base + index * step, per column or per row
task automatic set_vector(input int idx, input string name,
                          input pe_word_t w_base, input pe_word_t w_step,
                          input pe_word_t m_base, input pe_word_t m_step,
                          input int hold, input int k, input bit rnd);
    begin
        vec_name[idx]   = name;
        vec_hold[idx]   = hold;
        vec_acc[idx]    = k;
        vec_random[idx] = rnd;
        for (int j = 0; j < `PE_ARRAY_DIM; j++)
        begin
            vec_weight[idx][j] = w_base + pe_word_t'(j) * w_step;
            vec_map[idx][j]    = m_base + pe_word_t'(j) * m_step;
        end
    end
endtask

task automatic load_vectors();
    begin
        //         idx  name              w_base    w_step    m_base    m_step  hold  K  rnd
        set_vector(0,   "unit",           16'h0001, 16'h0000, 16'h0001, 16'h0000, 20,  1, 0);
        set_vector(1,   "routing",        16'h0100, 16'h0001, 16'h0010, 16'h0010, 20,  0, 0);
        set_vector(2,   "skew",           16'h0003, 16'h0001, 16'h0005, 16'h0002, 24,  5, 0);
        set_vector(3,   "long_run",       16'h0007, 16'h0003, 16'h000b, 16'h0001, 20, 30, 0);
        set_vector(4,   "random_wrap",    16'h0000, 16'h0000, 16'h0000, 16'h0000, 20, 40, 1);
        set_vector(5,   "random_reclear", 16'h0000, 16'h0000, 16'h0000, 16'h0000, 22,  3, 1);
        set_vector(6,   "reclear",        16'hfff1, 16'h0101, 16'h0203, 16'h0031, 20,  0, 0);
    end
endtask

`endif

//--- bench/pe_array_tb.sv
`timescale 1ns/1ps

`include "pe_array_consts.svh"

module pe_array_tb;

    import pe_data_pkg::*;

    localparam int DIM             = `PE_ARRAY_DIM;
    localparam int RESET_CYCLES    = 10;
    localparam int EDGE_TIMEOUT_NS = 100;   // ten clock periods per edge

    logic           clk;
    logic           rst_n;
    pe_word_vec_t   i_weight;
    pe_word_vec_t   i_map;
    logic           i_clear;
    pe_result_vec_t o_result;

`include "pe_array_vectors.svh"

    pe_array pe_array_i
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_weight (i_weight),
        .i_map    (i_map),
        .i_clear  (i_clear),
        .o_result (o_result)
    );

    // ==============================
    // clock
    // ==============================

    always #5 clk = ~clk;   // 10 ns period

    // ==============================
    // helpers
    // ==============================

    // n rising edges, or one falling edge, each bounded in time
    task automatic wait_edges(input int n, input bit on_fall, input string what);
        bit timed_out;
        begin
            timed_out = 1'b0;
            for (int i = 0; i < n; i++)
            begin
                fork
                    begin
                        if (on_fall)
                            @(negedge clk);
                        else
                            @(posedge clk);
                    end
                    begin
                        #(EDGE_TIMEOUT_NS);
                        timed_out = 1'b1;
                    end
                join_any
                disable fork;
                if (timed_out)
                begin
                    $display("Timeout: the clock stopped while waiting in %s", what);
                    $display("Result: FAILED");
                    $fatal(1, "no clock edge within the time limit");
                end
            end
        end
    endtask

    task automatic check_word(input string name, input pe_word_t expected,
                              input pe_word_t actual);
        begin
            if (actual !== expected)
            begin
                $display("Mismatch %s expected %h actual %h", name, expected, actual);
                $display("Result: FAILED");
                $fatal(1, "wrong result value");
            end
        end
    endtask

    // held operands, K edges after clear falls, tap min(r,c) lags by min+1
    function automatic pe_word_t model_result(input pe_word_t w, input pe_word_t m,
                                              input int r, input int c, input int k);
        int       tap;
        int       adds;
        pe_word_t prod;
        begin
            tap  = (r < c) ? r : c;
            prod = w * m;           // low 16 bits
            adds = k - (tap + 1);
            if (adds < 0)
                adds = 0;
            model_result = prod * pe_word_t'(1 + adds);
        end
    endfunction

    task automatic check_grid(input string name, input pe_word_vec_t w,
                              input pe_word_vec_t m, input int k);
        begin
            for (int r = 0; r < DIM; r++)
            begin
                for (int c = 0; c < DIM; c++)
                begin
                    check_word($sformatf("%s r%0d c%0d", name, r, c),
                               model_result(w[c], m[r], r, c, k),
                               o_result[r*DIM + c]);
                end
            end
        end
    endtask

    // ==============================
    // stimulus
    // ==============================

    initial
    begin
        pe_word_vec_t w;
        pe_word_vec_t m;

        clk      = 1'b0;
        rst_n    = 1'b0;
        i_weight = '0;
        i_map    = '0;
        i_clear  = 1'b0;

        void'($urandom(32'h4f89_7613));
        load_vectors();

        wait_edges(RESET_CYCLES, 1'b0, "reset");
        rst_n <= 1'b1;
        wait_edges(2, 1'b0, "reset release");
        wait_edges(1, 1'b1, "reset check");

        // nothing loaded yet
        for (int j = 0; j < DIM * DIM; j++)
        begin
            check_word($sformatf("reset element %0d", j), '0, o_result[j]);
        end

        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            w = vec_weight[i];
            m = vec_map[i];
            if (vec_random[i])
            begin
                for (int j = 0; j < DIM; j++)
                begin
                    w[j] = pe_word_t'($urandom);
                    m[j] = pe_word_t'($urandom);
                end
            end

            wait_edges(1, 1'b0, vec_name[i]);
            i_weight <= w;
            i_map    <= m;
            i_clear  <= 1'b1;

            // every PE reloads once operands and clear have crossed the grid
            wait_edges(vec_hold[i], 1'b0, vec_name[i]);
            wait_edges(1, 1'b1, vec_name[i]);
            check_grid({vec_name[i], " load"}, w, m, 0);

            wait_edges(1, 1'b0, vec_name[i]);
            i_clear <= 1'b0;
            wait_edges(vec_acc[i], 1'b0, vec_name[i]);
            wait_edges(1, 1'b1, vec_name[i]);
            check_grid({vec_name[i], " accumulate"}, w, m, vec_acc[i]);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- files.f
+incdir+rtl
+incdir+bench
rtl/pe_data_pkg.sv
rtl/pe_ctrl_pkg.sv
rtl/pe.sv
rtl/clear_skew.sv
rtl/pe_grid.sv
rtl/pe_array.sv
bench/pe_array_tb.sv

//--- Bender.yml
package:
  name: pe_array

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pe_data_pkg.sv
      - rtl/pe_ctrl_pkg.sv
      - rtl/pe.sv
      - rtl/clear_skew.sv
      - rtl/pe_grid.sv
      - rtl/pe_array.sv

  - target: simulation
    include_dirs:
      - rtl
      - bench
    files:
      - bench/pe_array_tb.sv
